//--- Makefile
VERILATOR ?= verilator
TOP       ?= ddr3_intf_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(BUILD_DIR)

//--- logic/ddr3_cmd_arbiter.sv
`timescale 1ns/1ps

module ddr3_cmd_arbiter (
    input  logic               ddr3_domain_clk,
    input  logic               arst_n,
    // high selects the write controller
    input  logic               acq_enabled,
    // write controller request
    input  logic               wr_req,
    input  ddr3_pkg::mem_cmd_t wr_cmd,
    output logic               wr_accept,
    // read controller request
    input  logic               rd_req,
    input  ddr3_pkg::mem_cmd_t rd_cmd,
    output logic               rd_accept,
    // memory command port
    output ddr3_pkg::mem_cmd_t app_cmd,
    output logic               app_en,
    input  logic               app_rdy
);
    import ddr3_pkg::*;

    mem_cmd_t cmd_q;
    logic     cmd_valid;
    logic     slot_free;
    logic     sel_req;
    logic     load;

    // register empty, or its command leaves this cycle
    assign slot_free = !cmd_valid || app_rdy;
    assign sel_req   = acq_enabled ? wr_req : rd_req;
    assign load      = slot_free && sel_req;

    // accept goes only to the selected source
    assign wr_accept = load && acq_enabled;
    assign rd_accept = load && !acq_enabled;

    // held stable until app_rdy takes it
    assign app_en  = cmd_valid;
    assign app_cmd = cmd_q;

    always_ff @(posedge ddr3_domain_clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else if (load) begin
            cmd_valid <= 1'b1;
        end else if (app_rdy) begin
            cmd_valid <= 1'b0;
        end
    end

    // command payload
    always_ff @(posedge ddr3_domain_clk) begin
        if (load) begin
            cmd_q <= acq_enabled ? wr_cmd : rd_cmd;
        end
    end

endmodule

//--- logic/ddr3_intf.sv
`timescale 1ns/1ps

module ddr3_intf #(
    parameter int HDR_DEPTH          = 16,
    parameter int RD_MAX_OUTSTANDING = 8
) (
    input  logic                   ddr3_domain_clk,
    input  logic                   arst_n,
    // write fifo from the acquisition path
    input  ddr3_pkg::wr_word_t     wr_fifo_dat,
    input  logic                   wr_fifo_empty,
    output logic                   wr_fifo_rd_en,
    // memory command port
    output ddr3_pkg::mem_cmd_t     app_cmd,
    output logic                   app_en,
    input  logic                   app_rdy,
    // memory write-data port
    output ddr3_pkg::mem_data_t    app_wdf_data,
    output logic                   app_wdf_wren,
    output logic                   app_wdf_end,
    input  logic                   app_wdf_rdy,
    // memory read-data port
    input  ddr3_pkg::mem_data_t    app_rd_data,
    input  logic                   app_rd_data_valid,
    // read fifo
    output logic                   rd_fifo_wr_en,
    output ddr3_pkg::mem_data_t    rd_fifo_dat,
    output logic                   rd_fifo_tlast,
    input  logic                   rd_fifo_almost_full,
    // header fifo read port
    output ddr3_pkg::fill_header_t fill_header_fifo_out,
    output logic                   fill_header_fifo_empty,
    input  logic                   fill_header_fifo_rd_en,
    // control and status
    input  logic                   acq_enabled,
    input  logic                   acq_done,
    input  logic                   enable_reading,
    input  ddr3_pkg::burst_addr_t  rd_start_addr,
    input  ddr3_pkg::burst_cnt_t   rd_burst_cnt,
    output logic                   wr_done,
    output logic                   reading_done
);
    import ddr3_pkg::*;

    logic         wr_req;
    mem_cmd_t     wr_cmd;
    logic         wr_accept;
    logic         rd_req;
    mem_cmd_t     rd_cmd;
    logic         rd_accept;
    fill_header_t hdr_dat;
    logic         hdr_push;
    logic         hdr_full;

    // write data straight from the fifo head
    assign app_wdf_data = wr_fifo_dat.data;

    // ************************************************************
    // command port owner
    // ************************************************************

    ddr3_cmd_arbiter u_cmd_arbiter (
        .ddr3_domain_clk (ddr3_domain_clk),
        .arst_n          (arst_n),
        .acq_enabled     (acq_enabled),
        .wr_req          (wr_req),
        .wr_cmd          (wr_cmd),
        .wr_accept       (wr_accept),
        .rd_req          (rd_req),
        .rd_cmd          (rd_cmd),
        .rd_accept       (rd_accept),
        .app_cmd         (app_cmd),
        .app_en          (app_en),
        .app_rdy         (app_rdy)
    );

    // ************************************************************
    // write side and its headers
    // ************************************************************

    ddr3_wr_control u_wr_control (
        .ddr3_domain_clk (ddr3_domain_clk),
        .arst_n          (arst_n),
        .acq_enabled     (acq_enabled),
        .acq_done        (acq_done),
        .wr_fifo_dat     (wr_fifo_dat),
        .wr_fifo_empty   (wr_fifo_empty),
        .wr_fifo_rd_en   (wr_fifo_rd_en),
        .wr_req          (wr_req),
        .wr_cmd          (wr_cmd),
        .wr_accept       (wr_accept),
        .app_wdf_wren    (app_wdf_wren),
        .app_wdf_end     (app_wdf_end),
        .app_wdf_rdy     (app_wdf_rdy),
        .hdr_dat         (hdr_dat),
        .hdr_push        (hdr_push),
        .hdr_full        (hdr_full),
        .wr_done         (wr_done)
    );

    fill_header_fifo #(
        .HDR_DEPTH (HDR_DEPTH)
    ) u_fill_header_fifo (
        .ddr3_domain_clk (ddr3_domain_clk),
        .arst_n          (arst_n),
        .din             (hdr_dat),
        .wr_en           (hdr_push),
        .full            (hdr_full),
        .rd_en           (fill_header_fifo_rd_en),
        .dout            (fill_header_fifo_out),
        .empty           (fill_header_fifo_empty)
    );

    // ************************************************************
    // read side
    // ************************************************************

    ddr3_rd_control #(
        .RD_MAX_OUTSTANDING (RD_MAX_OUTSTANDING)
    ) u_rd_control (
        .ddr3_domain_clk     (ddr3_domain_clk),
        .arst_n              (arst_n),
        .enable_reading      (enable_reading),
        .rd_start_addr       (rd_start_addr),
        .rd_burst_cnt        (rd_burst_cnt),
        .reading_done        (reading_done),
        .rd_req              (rd_req),
        .rd_cmd              (rd_cmd),
        .rd_accept           (rd_accept),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .rd_fifo_wr_en       (rd_fifo_wr_en),
        .rd_fifo_dat         (rd_fifo_dat),
        .rd_fifo_tlast       (rd_fifo_tlast),
        .rd_fifo_almost_full (rd_fifo_almost_full)
    );

endmodule

//--- logic/ddr3_pkg.sv
package ddr3_pkg;

    // ************************************************************
    // widths with a meaning
    // ************************************************************

    // index of one 128-bit burst
    typedef logic [22:0]  burst_addr_t;
    // bursts in a fill or a read job
    typedef logic [23:0]  burst_cnt_t;
    // controller address, 16-bit word granularity
    typedef logic [26:0]  app_addr_t;
    typedef logic [2:0]   app_cmd_t;
    typedef logic [127:0] mem_data_t;
    typedef logic [3:0]   wr_tag_t;

    // app_cmd encodings of the memory controller
    localparam app_cmd_t CMD_WRITE = 3'd0;
    localparam app_cmd_t CMD_READ  = 3'd1;

    // first word of a new fill, any other tag is plain data
    localparam wr_tag_t TAG_FILL_START = 4'd1;

    // ************************************************************
    // bundles
    // ************************************************************

    // tag sits in bits 131:128
    typedef struct packed {
        wr_tag_t   tag;
        mem_data_t data;
    } wr_word_t;

    typedef struct packed {
        burst_addr_t start_addr;
        burst_cnt_t  burst_cnt;
    } fill_header_t;

    typedef struct packed {
        app_addr_t addr;
        app_cmd_t  cmd;
    } mem_cmd_t;

    // ************************************************************
    // controller states
    // ************************************************************

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_CMD,
        WR_DATA,
        WR_CLOSE,
        WR_DONE
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_RUN,
        RD_DONE
    } rd_state_t;

    // 8 words of 16 bits per burst
    function automatic app_addr_t burst_to_app(burst_addr_t burst);
        return {1'b0, burst, 3'b000};
    endfunction

endpackage

//--- logic/ddr3_rd_control.sv
`timescale 1ns/1ps

module ddr3_rd_control #(
    parameter int RD_MAX_OUTSTANDING = 8
) (
    input  logic                  ddr3_domain_clk,
    input  logic                  arst_n,
    // job control
    input  logic                  enable_reading,
    input  ddr3_pkg::burst_addr_t rd_start_addr,
    input  ddr3_pkg::burst_cnt_t  rd_burst_cnt,
    output logic                  reading_done,
    // request to the command arbiter
    output logic                  rd_req,
    output ddr3_pkg::mem_cmd_t    rd_cmd,
    input  logic                  rd_accept,
    // memory read-data port, in command order
    input  ddr3_pkg::mem_data_t   app_rd_data,
    input  logic                  app_rd_data_valid,
    // downstream read fifo
    output logic                  rd_fifo_wr_en,
    output ddr3_pkg::mem_data_t   rd_fifo_dat,
    output logic                  rd_fifo_tlast,
    input  logic                  rd_fifo_almost_full
);
    import ddr3_pkg::*;

    localparam int INFL_W = $clog2(RD_MAX_OUTSTANDING + 1);

    rd_state_t          state;
    logic               en_q;
    logic               job_start;
    burst_addr_t        rd_addr;
    // commands still to issue
    burst_cnt_t         cmd_left;
    // beats still to receive
    burst_cnt_t         beats_left;
    // accepted commands without data yet
    logic [INFL_W-1:0]  in_flight;

    // rising edge of enable_reading starts a job
    assign job_start = enable_reading && !en_q;

    assign rd_req = (state == RD_RUN) && (cmd_left != '0) &&
                    (in_flight < INFL_W'(RD_MAX_OUTSTANDING)) && !rd_fifo_almost_full;
    assign rd_cmd = '{addr: burst_to_app(rd_addr), cmd: CMD_READ};

    assign reading_done = (state == RD_DONE);

    // ************************************************************
    // job tracking
    // ************************************************************

    always_ff @(posedge ddr3_domain_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RD_IDLE;
            en_q       <= 1'b0;
            rd_addr    <= '0;
            cmd_left   <= '0;
            beats_left <= '0;
        end else begin
            en_q <= enable_reading;
            case (state)
                RD_IDLE, RD_DONE: begin
                    if (job_start) begin
                        rd_addr    <= rd_start_addr;
                        cmd_left   <= rd_burst_cnt;
                        beats_left <= rd_burst_cnt;
                        // empty job finishes at once
                        state      <= (rd_burst_cnt == '0) ? RD_DONE : RD_RUN;
                    end
                end
                RD_RUN: begin
                    // address generator steps per accepted command
                    if (rd_accept) begin
                        rd_addr  <= rd_addr + 1'b1;
                        cmd_left <= cmd_left - 1'b1;
                    end
                    if (app_rd_data_valid) begin
                        beats_left <= beats_left - 1'b1;
                    end
                    // done one cycle after the tlast beat
                    if (rd_fifo_wr_en && rd_fifo_tlast) begin
                        state <= RD_DONE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // in-flight count, up on accept and down on each beat
    always_ff @(posedge ddr3_domain_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
        end else begin
            case ({rd_accept, app_rd_data_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // ************************************************************
    // returned data, one cycle later
    // ************************************************************

    always_ff @(posedge ddr3_domain_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_fifo_wr_en <= 1'b0;
            rd_fifo_tlast <= 1'b0;
        end else begin
            rd_fifo_wr_en <= app_rd_data_valid;
            rd_fifo_tlast <= app_rd_data_valid && (beats_left == burst_cnt_t'(1));
        end
    end

    always_ff @(posedge ddr3_domain_clk) begin
        if (app_rd_data_valid) begin
            rd_fifo_dat <= app_rd_data;
        end
    end

endmodule

//--- logic/ddr3_wr_control.sv
`timescale 1ns/1ps

module ddr3_wr_control (
    input  logic                   ddr3_domain_clk,
    input  logic                   arst_n,
    // acquisition mode and its end
    input  logic                   acq_enabled,
    input  logic                   acq_done,
    // upstream write fifo, head valid while not empty
    input  ddr3_pkg::wr_word_t     wr_fifo_dat,
    input  logic                   wr_fifo_empty,
    output logic                   wr_fifo_rd_en,
    // request to the command arbiter
    output logic                   wr_req,
    output ddr3_pkg::mem_cmd_t     wr_cmd,
    input  logic                   wr_accept,
    // memory write-data port
    output logic                   app_wdf_wren,
    output logic                   app_wdf_end,
    input  logic                   app_wdf_rdy,
    // header fifo push side
    output ddr3_pkg::fill_header_t hdr_dat,
    output logic                   hdr_push,
    input  logic                   hdr_full,
    output logic                   wr_done
);
    import ddr3_pkg::*;

    wr_state_t   state;
    // next burst to write
    burst_addr_t wr_addr;
    // first burst of the open fill
    burst_addr_t fill_start;
    // bursts written into the open fill
    burst_cnt_t  fill_cnt;
    logic        head_starts_fill;
    logic        fill_open;

    assign head_starts_fill = !wr_fifo_empty && (wr_fifo_dat.tag == TAG_FILL_START);
    assign fill_open        = (fill_cnt != '0);

    // ************************************************************
    // outputs decoded from state
    // ************************************************************

    assign wr_req = (state == WR_CMD);
    assign wr_cmd = '{addr: burst_to_app(wr_addr), cmd: CMD_WRITE};

    // one beat per burst, so end follows wren
    assign app_wdf_wren = (state == WR_DATA);
    assign app_wdf_end  = (state == WR_DATA);
    // pop together with the data transfer
    assign wr_fifo_rd_en = (state == WR_DATA) && app_wdf_rdy;

    assign hdr_dat  = '{start_addr: fill_start, burst_cnt: fill_cnt};
    // full fifo holds the close and every later pop
    assign hdr_push = (state == WR_CLOSE) && !hdr_full;
    assign wr_done  = (state == WR_DONE);

    // ************************************************************
    // one word at a time
    // ************************************************************

    always_ff @(posedge ddr3_domain_clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= WR_IDLE;
            wr_addr    <= '0;
            fill_start <= '0;
            fill_cnt   <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (!acq_enabled) begin
                        // next acquisition starts at burst 0
                        wr_addr    <= '0;
                        fill_start <= '0;
                        fill_cnt   <= '0;
                    end else if (head_starts_fill && fill_open) begin
                        // new fill tag closes the current one first
                        state <= WR_CLOSE;
                    end else if (!wr_fifo_empty) begin
                        state <= WR_CMD;
                    end else if (acq_done) begin
                        state <= fill_open ? WR_CLOSE : WR_DONE;
                    end
                end
                WR_CMD: begin
                    if (wr_accept) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (app_wdf_rdy) begin
                        wr_addr  <= wr_addr + 1'b1;
                        fill_cnt <= fill_cnt + 1'b1;
                        state    <= WR_IDLE;
                    end
                end
                WR_CLOSE: begin
                    if (!hdr_full) begin
                        // next fill opens where this one ended
                        fill_start <= wr_addr;
                        fill_cnt   <= '0;
                        state      <= (acq_done && wr_fifo_empty) ? WR_DONE : WR_IDLE;
                    end
                end
                WR_DONE: begin
                    // held until acquisition mode drops
                    if (!acq_enabled) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

//--- logic/fill_header_fifo.sv
`timescale 1ns/1ps

module fill_header_fifo #(
    parameter int HDR_DEPTH = 16
) (
    input  logic                   ddr3_domain_clk,
    input  logic                   arst_n,
    // push side
    input  ddr3_pkg::fill_header_t din,
    input  logic                   wr_en,
    output logic                   full,
    // show-ahead pop side
    input  logic                   rd_en,
    output ddr3_pkg::fill_header_t dout,
    output logic                   empty
);
    import ddr3_pkg::*;

    localparam int PTR_W = $clog2(HDR_DEPTH);
    localparam int CNT_W = $clog2(HDR_DEPTH + 1);

    fill_header_t       mem [HDR_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_wr;
    logic               do_rd;

    // ignore push when full and pop when empty
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == CNT_W'(HDR_DEPTH));
    assign empty = (count == '0);
    // oldest entry visible while not empty
    assign dout  = mem[rd_ptr];

    always_ff @(posedge ddr3_domain_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(HDR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(HDR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count unchanged
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge ddr3_domain_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

//--- sim.f
logic/ddr3_pkg.sv
logic/ddr3_cmd_arbiter.sv
logic/ddr3_wr_control.sv
logic/ddr3_rd_control.sv
logic/fill_header_fifo.sv
logic/ddr3_intf.sv
verif/ddr3_app_model.sv
verif/ddr3_intf_tb.sv

//--- verif/ddr3_app_model.sv
`timescale 1ns/1ps

module ddr3_app_model (
    input  logic                ddr3_domain_clk,
    input  logic                arst_n,
    // command port
    input  ddr3_pkg::mem_cmd_t  app_cmd,
    input  logic                app_en,
    output logic                app_rdy,
    // write-data port
    input  ddr3_pkg::mem_data_t app_wdf_data,
    input  logic                app_wdf_wren,
    output logic                app_wdf_rdy,
    // read-data port, in command order
    output ddr3_pkg::mem_data_t app_rd_data,
    output logic                app_rd_data_valid
);
    import ddr3_pkg::*;

    localparam int MEM_DEPTH = 64;

    mem_data_t   mem [MEM_DEPTH];
    // writes pair a command with a data beat, in order
    app_addr_t   wr_addr_q [$];
    mem_data_t   wr_data_q [$];
    // pending reads and the cycle each one is due
    app_addr_t   rd_addr_q [$];
    int          rd_due_q [$];
    int          cycle;
    int          last_due;
    int          due;
    int          rd_delay;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rng               = 32'hdef6;
        cycle             = 0;
        last_due          = 0;
        rd_delay          = 2;
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
    end

    // transfers seen with the values just before the edge
    always @(posedge ddr3_domain_clk) begin
        if (arst_n) begin
            cycle = cycle + 1;
            if (app_en && app_rdy) begin
                if (app_cmd.cmd == CMD_WRITE) begin
                    wr_addr_q.push_back(app_cmd.addr);
                end else begin
                    due = cycle + rd_delay;
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    rd_addr_q.push_back(app_cmd.addr);
                    rd_due_q.push_back(due);
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wr_data_q.push_back(app_wdf_data);
            end
            while (wr_addr_q.size() != 0 && wr_data_q.size() != 0) begin
                mem[wr_addr_q[0][8:3]] = wr_data_q[0];
                void'(wr_addr_q.pop_front());
                void'(wr_data_q.pop_front());
            end
        end
    end

    // ************************************************************
    // ready stalls and read returns, driven on the falling edge
    // ************************************************************

    always @(negedge ddr3_domain_clk) begin
        app_rd_data_valid = 1'b0;
        if (!arst_n) begin
            app_rdy     = 1'b0;
            app_wdf_rdy = 1'b0;
        end else begin
            rng         = xorshift(rng);
            // roughly three cycles in four ready
            app_rdy     = (rng[1:0] != 2'b00);
            app_wdf_rdy = (rng[3:2] != 2'b00);
            // 2 to 6 cycles of read latency
            rd_delay    = 2 + int'(rng[10:8] % 3'd5);
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle) begin
                app_rd_data_valid = 1'b1;
                app_rd_data       = mem[rd_addr_q[0][8:3]];
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
        end
    end

endmodule

//--- verif/ddr3_intf_tb.sv
`timescale 1ns/1ps

module ddr3_intf_tb;
    import ddr3_pkg::*;

    localparam int     NUM_FILLS = 4;
    localparam int     NUM_WORDS = 20;
    localparam realtime CLK_PERIOD = 8.0;
    localparam realtime WATCHDOG = (40 * NUM_WORDS + 2000) * CLK_PERIOD;

    logic ddr3_domain_clk = 1'b0;
    logic arst_n;
    wr_word_t wr_fifo_dat;
    logic wr_fifo_empty;
    logic wr_fifo_rd_en;
    mem_cmd_t app_cmd;
    logic app_en;
    logic app_rdy;
    mem_data_t app_wdf_data;
    mem_data_t app_rd_data;
    mem_data_t rd_fifo_dat;
    logic app_wdf_wren;
    logic app_wdf_end;
    logic app_wdf_rdy;
    logic app_rd_data_valid;
    logic rd_fifo_wr_en;
    logic rd_fifo_tlast;
    logic rd_fifo_almost_full;
    fill_header_t fill_header_fifo_out;
    logic fill_header_fifo_empty;
    logic fill_header_fifo_rd_en;
    logic acq_enabled;
    logic acq_done;
    logic enable_reading;
    logic wr_done;
    logic reading_done;
    burst_addr_t rd_start_addr;
    burst_cnt_t rd_burst_cnt;

    int fill_len [NUM_FILLS] = '{6, 1, 9, 4};
    wr_word_t words [$];
    wr_word_t wr_fifo_q [$];
    fill_header_t exp_hdr [$];
    logic [31:0] rng = 32'hdef6;
    int value_errors = 0;
    int other_errors = 0;
    int rd_base;
    int rd_len;
    int beat;
    int af_cnt;

    always #(CLK_PERIOD / 2) ddr3_domain_clk = ~ddr3_domain_clk;

    ddr3_intf UUT (.*);

    ddr3_app_model u_app_model (
        .ddr3_domain_clk   (ddr3_domain_clk),
        .arst_n            (arst_n),
        .app_cmd           (app_cmd),
        .app_en            (app_en),
        .app_rdy           (app_rdy),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one header per fill, start is the count of words before it
    function automatic void expected_headers();
        int start;
        int cnt;
        start = 0;
        cnt   = 0;
        exp_hdr.delete();
        for (int i = 0; i < words.size(); i++) begin
            if (words[i].tag == TAG_FILL_START && cnt > 0) begin
                exp_hdr.push_back('{start_addr: burst_addr_t'(start),
                                    burst_cnt: burst_cnt_t'(cnt)});
                start = i;
                cnt   = 0;
            end
            cnt++;
        end
        if (cnt > 0) begin
            exp_hdr.push_back('{start_addr: burst_addr_t'(start),
                                burst_cnt: burst_cnt_t'(cnt)});
        end
    endfunction

    task automatic report_value(input string name, input logic [131:0] got, exp);
        $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        value_errors++;
    endtask

    // ************************************************************
    // write fifo, popped on rd_en and refreshed on the falling edge
    // ************************************************************

    always @(posedge ddr3_domain_clk) begin
        if (arst_n && wr_fifo_rd_en) begin
            if (wr_fifo_empty) begin
                $display("t=%0t write fifo popped while empty", $time);
                other_errors++;
            end else begin
                void'(wr_fifo_q.pop_front());
            end
        end
        // read commands stop within 2 cycles of almost_full
        af_cnt = rd_fifo_almost_full ? af_cnt + 1 : 0;
        if (af_cnt > 2 && UUT.rd_accept) begin
            $display("t=%0t read command accepted under almost_full", $time);
            other_errors++;
        end
    end

    always @(negedge ddr3_domain_clk) begin
        wr_fifo_empty = (wr_fifo_q.size() == 0);
        wr_fifo_dat   = wr_fifo_empty ? '0 : wr_fifo_q[0];
    end

    // one beat per burst, so every write beat is also the last
    always @(negedge ddr3_domain_clk) begin
        if (arst_n && app_wdf_wren && app_wdf_end !== 1'b1) begin
            report_value("app_wdf_end", 132'(app_wdf_end), 132'(1'b1));
        end
    end

    // read beats against the written words
    always @(negedge ddr3_domain_clk) begin
        if (rd_fifo_wr_en) begin
            if (beat >= rd_len) begin
                $display("t=%0t read beat beyond the job length", $time);
                other_errors++;
            end else begin
                if (rd_fifo_dat !== words[rd_base + beat].data) begin
                    report_value("rd_fifo_dat", 132'(rd_fifo_dat),
                                 132'(words[rd_base + beat].data));
                end
                if (rd_fifo_tlast !== (beat == rd_len - 1)) begin
                    report_value("rd_fifo_tlast", 132'(rd_fifo_tlast),
                                 132'(beat == rd_len - 1));
                end
            end
            beat++;
        end else if (rd_fifo_tlast) begin
            report_value("rd_fifo_tlast", 132'(rd_fifo_tlast), 132'(1'b0));
        end
    end

    task automatic run_read(input int base, input int len, input bit throttle);
        rd_base = base;
        rd_len  = len;
        beat    = 0;
        @(negedge ddr3_domain_clk);
        rd_start_addr  = burst_addr_t'(base);
        rd_burst_cnt   = burst_cnt_t'(len);
        enable_reading = 1'b1;
        @(negedge ddr3_domain_clk);
        enable_reading = 1'b0;
        while (!reading_done) begin
            rng = xorshift(rng);
            rd_fifo_almost_full = throttle && (rng[2:0] < 3'd3);
            @(negedge ddr3_domain_clk);
        end
        rd_fifo_almost_full = 1'b0;
        if (beat != len) begin
            report_value("read beats", 132'(beat), 132'(len));
        end
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************

    initial begin
        arst_n = 1'b0;
        wr_fifo_dat = '0;
        wr_fifo_empty = 1'b1;
        rd_fifo_almost_full = 1'b0;
        fill_header_fifo_rd_en = 1'b0;
        acq_enabled = 1'b0;
        acq_done = 1'b0;
        enable_reading = 1'b0;
        rd_start_addr = '0;
        rd_burst_cnt = '0;
        af_cnt = 0;
        beat = 0;
        rd_len = 0;
        rd_base = 0;
        repeat (4) @(negedge ddr3_domain_clk);
        arst_n = 1'b1;
        @(negedge ddr3_domain_clk);
        if ({wr_fifo_rd_en, app_en, app_wdf_wren, rd_fifo_wr_en, rd_fifo_tlast,
             wr_done, reading_done} != 7'b0) begin
            $display("t=%0t control outputs not low after reset", $time);
            other_errors++;
        end
        // fills of tagged first words and random data
        for (int f = 0; f < NUM_FILLS; f++) begin
            for (int i = 0; i < fill_len[f]; i++) begin
                wr_word_t w;
                rng = xorshift(rng);
                w.tag = (i == 0) ? TAG_FILL_START : wr_tag_t'(rng[3:2] == 0 ? 0 : rng[3:2] + 1);
                w.data = {rng, ~rng, rng ^ 32'(words.size()), 32'(words.size())};
                words.push_back(w);
                wr_fifo_q.push_back(w);
            end
        end
        expected_headers();
        acq_enabled = 1'b1;
        while (wr_fifo_q.size() != 0) @(negedge ddr3_domain_clk);
        acq_done = 1'b1;
        while (!wr_done) @(negedge ddr3_domain_clk);
        acq_done = 1'b0;
        // last write command may still wait on app_rdy
        while (app_en) @(negedge ddr3_domain_clk);
        for (int i = 0; i < NUM_WORDS; i++) begin
            if (u_app_model.mem[i] !== words[i].data) begin
                report_value($sformatf("mem[%0d]", i), 132'(u_app_model.mem[i]),
                             132'(words[i].data));
            end
        end
        foreach (exp_hdr[i]) begin
            if (fill_header_fifo_empty) begin
                $display("t=%0t header fifo empty before header %0d", $time, i);
                other_errors++;
            end else if (fill_header_fifo_out !== exp_hdr[i]) begin
                report_value("fill_header_fifo_out", 132'(fill_header_fifo_out),
                             132'(exp_hdr[i]));
            end
            fill_header_fifo_rd_en = 1'b1;
            @(negedge ddr3_domain_clk);
            fill_header_fifo_rd_en = 1'b0;
        end
        if (!fill_header_fifo_empty) begin
            $display("t=%0t header fifo holds extra headers", $time);
            other_errors++;
        end
        acq_enabled = 1'b0;
        @(negedge ddr3_domain_clk);
        run_read(3, 12, 1'b0);
        run_read(0, NUM_WORDS, 1'b1);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
